/* rtl/dram_params.svh */
`ifndef DRAM_PARAMS_SVH
`define DRAM_PARAMS_SVH

// Bus widths
`define DRAM_DATA_W      32
`define DRAM_STRB_W      4
`define DRAM_ID_W        4
`define DRAM_LEN_W       4
`define DRAM_AXI_ADDR_W  23

// Word address split into row and column
`define DRAM_ROW_W       11
`define DRAM_COL_W       10
`define DRAM_WORD_LSB    2

// Strobe timing in clock cycles
`define DRAM_T_RCD       4
`define DRAM_T_CAS       4
`define DRAM_T_RP        4

`endif

/* rtl/dram_pkg.sv */
`default_nettype none

`include "dram_params.svh"

package dram_pkg;

  // Row and column fields of a word address
  typedef struct packed {
    logic [`DRAM_ROW_W-1:0] row;
    logic [`DRAM_COL_W-1:0] col;
  } dram_rc_t;

  // Same word seen as a flat index or as row/column
  typedef union packed {
    logic [`DRAM_ROW_W+`DRAM_COL_W-1:0] word;
    dram_rc_t                           rc;
  } dram_addr_u;

  typedef enum logic [2:0] {
    IDLE,
    ACTIVATE,
    READ_CAS,
    READ_HOLD,
    WRITE_CAS,
    PRECHARGE
  } seq_state_e;

endpackage

`default_nettype wire

/* rtl/dram_axi_slave.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dram_params.svh"

module dram_axi_slave (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        awvalid_i,
  output logic                             awready_o,
  input  wire logic [`DRAM_AXI_ADDR_W-1:0] awaddr_i,
  input  wire logic [`DRAM_ID_W-1:0]       awid_i,
  input  wire logic                        wvalid_i,
  output logic                             wready_o,
  input  wire logic [`DRAM_DATA_W-1:0]     wdata_i,
  input  wire logic [`DRAM_STRB_W-1:0]     wstrb_i,
  input  wire logic                        arvalid_i,
  output logic                             arready_o,
  input  wire logic [`DRAM_AXI_ADDR_W-1:0] araddr_i,
  input  wire logic [`DRAM_ID_W-1:0]       arid_i,
  input  wire logic [`DRAM_LEN_W-1:0]      arlen_i,
  output logic                             rvalid_o,
  input  wire logic                        rready_i,
  output logic [`DRAM_DATA_W-1:0]          rdata_o,
  output logic [`DRAM_ID_W-1:0]            rid_o,
  output logic                             rlast_o,
  output logic [1:0]                       rresp_o,
  output logic                             bvalid_o,
  input  wire logic                        bready_i,
  output logic [`DRAM_ID_W-1:0]            bid_o,
  output logic [1:0]                       bresp_o,
  output logic                             req_valid_o,
  output logic                             req_write_o,
  output dram_pkg::dram_addr_u             req_addr_o,
  output logic [`DRAM_LEN_W-1:0]           req_len_o,
  output logic [`DRAM_STRB_W-1:0]          req_strb_o,
  output logic [`DRAM_DATA_W-1:0]          req_data_o,
  input  wire logic                        beat_valid_i,
  input  wire logic [`DRAM_DATA_W-1:0]     beat_data_i,
  output logic                             beat_ready_o,
  input  wire logic                        done_i
);

  logic                          busy_q;
  logic                          write_q;
  logic                          req_valid_q;
  logic                          bvalid_q;
  logic [`DRAM_LEN_W-1:0]        beat_cnt_q;
  logic [`DRAM_ID_W-1:0]         id_q;
  dram_pkg::dram_addr_u          addr_q;
  logic [`DRAM_LEN_W-1:0]        len_q;
  logic [`DRAM_STRB_W-1:0]       strb_q;
  logic [`DRAM_DATA_W-1:0]       data_q;
  logic                          wr_accept;
  logic                          rd_accept;
  logic                          r_hs;
  logic                          b_hs;

  // AW and W are taken together, write wins over AR
  assign awready_o = ~busy_q & awvalid_i & wvalid_i;
  assign wready_o  = awready_o;
  assign arready_o = ~busy_q & arvalid_i & ~awvalid_i;

  assign wr_accept = awvalid_i & awready_o;
  assign rd_accept = arvalid_i & arready_o;
  assign r_hs      = rvalid_o & rready_i;
  assign b_hs      = bvalid_o & bready_i;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy_q      <= 1'b0;
      write_q     <= 1'b0;
      req_valid_q <= 1'b0;
      bvalid_q    <= 1'b0;
      beat_cnt_q  <= '0;
    end else begin
      req_valid_q <= wr_accept | rd_accept;
      if (wr_accept | rd_accept) begin
        busy_q     <= 1'b1;
        write_q    <= wr_accept;
        beat_cnt_q <= '0;
      end else if (r_hs) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      if (done_i && write_q) begin
        bvalid_q <= 1'b1;
      end else if (b_hs) begin
        bvalid_q <= 1'b0;
      end
      // Reads finish at the precharge after the last beat
      if (b_hs || (done_i && !write_q)) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      id_q        <= awid_i;
      addr_q.word <= awaddr_i[`DRAM_AXI_ADDR_W-1:`DRAM_WORD_LSB];
      len_q       <= '0;
      strb_q      <= wstrb_i;
      data_q      <= wdata_i;
    end else if (rd_accept) begin
      id_q        <= arid_i;
      addr_q.word <= araddr_i[`DRAM_AXI_ADDR_W-1:`DRAM_WORD_LSB];
      len_q       <= arlen_i;
    end
  end

  // Current beat address, burst stays inside one row
  always_comb begin
    req_addr_o      = addr_q;
    req_addr_o.word = addr_q.word +
      {{(`DRAM_ROW_W + `DRAM_COL_W - `DRAM_LEN_W){1'b0}}, beat_cnt_q};
  end

  assign req_valid_o  = req_valid_q;
  assign req_write_o  = write_q;
  assign req_len_o    = len_q;
  assign req_strb_o   = strb_q;
  assign req_data_o   = data_q;

  assign beat_ready_o = rready_i;
  assign rvalid_o     = beat_valid_i;
  assign rdata_o      = beat_data_i;
  assign rid_o        = id_q;
  assign rlast_o      = (beat_cnt_q == len_q);
  assign rresp_o      = 2'b00;  // OKAY

  assign bvalid_o     = bvalid_q;
  assign bid_o        = id_q;
  assign bresp_o      = 2'b00;

  // Stalled R beat must not change
  r_stable_a : assert property (@(posedge clk) disable iff (!rst)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rid_o) &&
      $stable(rlast_o))
    else $error("R payload changed while stalled");

  // A pending write response blocks new requests
  ready_excl_a : assert property (@(posedge clk) disable iff (!rst)
    bvalid_o |-> !(awready_o || arready_o))
    else $error("request accepted before the B handshake");

endmodule

`default_nettype wire

/* rtl/dram_seq.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dram_params.svh"

module dram_seq (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    req_valid_i,
  input  wire logic                    req_write_i,
  input  wire dram_pkg::dram_addr_u    req_addr_i,
  input  wire logic [`DRAM_LEN_W-1:0]  req_len_i,
  input  wire logic [`DRAM_STRB_W-1:0] req_strb_i,
  input  wire logic [`DRAM_DATA_W-1:0] req_data_i,
  output logic                         beat_valid_o,
  output logic [`DRAM_DATA_W-1:0]      beat_data_o,
  input  wire logic                    beat_ready_i,
  output logic                         done_o,
  output logic                         dram_csn_o,
  output logic                         dram_rasn_o,
  output logic                         dram_casn_o,
  output logic [`DRAM_STRB_W-1:0]      dram_wen_o,
  output logic [`DRAM_ROW_W-1:0]       dram_a_o,
  output logic [`DRAM_DATA_W-1:0]      dram_d_o,
  input  wire logic [`DRAM_DATA_W-1:0] dram_q_i,
  input  wire logic                    dram_valid_i
);

  // Last cycle index of each timed state
  localparam logic [2:0] RCD_LAST = 3'(`DRAM_T_RCD - 1);
  localparam logic [2:0] CAS_LAST = 3'(`DRAM_T_CAS - 1);
  localparam logic [2:0] RP_LAST  = 3'(`DRAM_T_RP - 1);

  dram_pkg::seq_state_e        state_q;
  dram_pkg::seq_state_e        state_d;
  logic [2:0]                  dly_q;
  logic [`DRAM_LEN_W-1:0]      beat_cnt_q;
  logic [`DRAM_DATA_W-1:0]     beat_q;
  logic                        done_q;
  logic                        row_open_q;
  logic                        last_beat;
  logic [`DRAM_ROW_W-1:0]      col_a;

  assign last_beat = (beat_cnt_q == req_len_i);
  assign col_a     = {{(`DRAM_ROW_W - `DRAM_COL_W){1'b0}}, req_addr_i.rc.col};

  always_comb begin
    state_d = state_q;
    case (state_q)
      dram_pkg::IDLE: begin
        if (req_valid_i) state_d = dram_pkg::ACTIVATE;
      end
      dram_pkg::ACTIVATE: begin
        if (dly_q == RCD_LAST) begin
          state_d = req_write_i ? dram_pkg::WRITE_CAS : dram_pkg::READ_CAS;
        end
      end
      dram_pkg::READ_CAS: begin
        if (dram_valid_i) state_d = dram_pkg::READ_HOLD;
      end
      dram_pkg::READ_HOLD: begin
        if (beat_ready_i) state_d = last_beat ? dram_pkg::PRECHARGE : dram_pkg::READ_CAS;
      end
      dram_pkg::WRITE_CAS: begin
        if (dly_q == CAS_LAST) state_d = dram_pkg::PRECHARGE;
      end
      dram_pkg::PRECHARGE: begin
        if (dly_q == RP_LAST) state_d = dram_pkg::IDLE;
      end
      default: state_d = dram_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q    <= dram_pkg::IDLE;
      dly_q      <= '0;
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
      row_open_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Restarts on every state change, saturates while waiting for data
      if (state_d != state_q) begin
        dly_q <= '0;
      end else if (dly_q != 3'h7) begin
        dly_q <= dly_q + 3'h1;
      end
      if (state_q == dram_pkg::IDLE) begin
        beat_cnt_q <= '0;
      end else if (state_q == dram_pkg::READ_HOLD && beat_ready_i) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      done_q <= (state_q == dram_pkg::PRECHARGE) && (state_d == dram_pkg::IDLE);
      if (state_q == dram_pkg::ACTIVATE && !dram_rasn_o) begin
        row_open_q <= 1'b1;
      end else if (state_q == dram_pkg::PRECHARGE && !dram_rasn_o) begin
        row_open_q <= 1'b0;
      end
    end
  end

  // Read data held until the R handshake
  always_ff @(posedge clk) begin
    if (state_q == dram_pkg::READ_CAS && dram_valid_i) begin
      beat_q <= dram_q_i;
    end
  end

  assign beat_valid_o = (state_q == dram_pkg::READ_HOLD);
  assign beat_data_o  = beat_q;
  assign done_o       = done_q;

  always_comb begin
    dram_csn_o  = 1'b0;
    dram_rasn_o = 1'b1;
    dram_casn_o = 1'b1;
    dram_wen_o  = '1;
    dram_a_o    = req_addr_i.rc.row;
    dram_d_o    = '0;
    case (state_q)
      dram_pkg::IDLE: dram_csn_o = 1'b1;
      dram_pkg::ACTIVATE: dram_rasn_o = (dly_q != 3'h0);
      dram_pkg::READ_CAS: begin
        dram_casn_o = (dly_q != 3'h0);
        dram_a_o    = col_a;
      end
      dram_pkg::READ_HOLD: dram_a_o = col_a;
      dram_pkg::WRITE_CAS: begin
        // Byte enables are the inverted write strobe
        dram_casn_o = 1'b0;
        dram_wen_o  = ~req_strb_i;
        dram_a_o    = col_a;
        dram_d_o    = req_data_i;
      end
      dram_pkg::PRECHARGE: begin
        dram_rasn_o = (dly_q != 3'h0);
        dram_wen_o  = (dly_q == 3'h0) ? '0 : '1;
      end
      default: dram_csn_o = 1'b1;
    endcase
  end

  ras_cas_excl_a : assert property (@(posedge clk) disable iff (!rst)
    !(!dram_rasn_o && !dram_casn_o))
    else $error("RAS and CAS low together");

  // CAS only between ACTIVATE and the following precharge
  cas_row_open_a : assert property (@(posedge clk) disable iff (!rst)
    !dram_casn_o |-> row_open_q)
    else $error("CAS issued with no open row");

endmodule

`default_nettype wire

/* rtl/dram_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dram_params.svh"

module dram_subsys (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        awvalid_i,
  output logic                             awready_o,
  input  wire logic [`DRAM_AXI_ADDR_W-1:0] awaddr_i,
  input  wire logic [`DRAM_ID_W-1:0]       awid_i,
  input  wire logic                        wvalid_i,
  output logic                             wready_o,
  input  wire logic [`DRAM_DATA_W-1:0]     wdata_i,
  input  wire logic [`DRAM_STRB_W-1:0]     wstrb_i,
  input  wire logic                        arvalid_i,
  output logic                             arready_o,
  input  wire logic [`DRAM_AXI_ADDR_W-1:0] araddr_i,
  input  wire logic [`DRAM_ID_W-1:0]       arid_i,
  input  wire logic [`DRAM_LEN_W-1:0]      arlen_i,
  output logic                             rvalid_o,
  input  wire logic                        rready_i,
  output logic [`DRAM_DATA_W-1:0]          rdata_o,
  output logic [`DRAM_ID_W-1:0]            rid_o,
  output logic                             rlast_o,
  output logic [1:0]                       rresp_o,
  output logic                             bvalid_o,
  input  wire logic                        bready_i,
  output logic [`DRAM_ID_W-1:0]            bid_o,
  output logic [1:0]                       bresp_o,
  output logic                             dram_csn_o,
  output logic                             dram_rasn_o,
  output logic                             dram_casn_o,
  output logic [`DRAM_STRB_W-1:0]          dram_wen_o,
  output logic [`DRAM_ROW_W-1:0]           dram_a_o,
  output logic [`DRAM_DATA_W-1:0]          dram_d_o,
  input  wire logic [`DRAM_DATA_W-1:0]     dram_q_i,
  input  wire logic                        dram_valid_i
);

  // Request and beat path between slave and sequencer
  logic                    req_valid;
  logic                    req_write;
  dram_pkg::dram_addr_u    req_addr;
  logic [`DRAM_LEN_W-1:0]  req_len;
  logic [`DRAM_STRB_W-1:0] req_strb;
  logic [`DRAM_DATA_W-1:0] req_data;
  logic                    beat_valid;
  logic [`DRAM_DATA_W-1:0] beat_data;
  logic                    beat_ready;
  logic                    done;

  dram_axi_slave i_slave (
    .clk         (clk),
    .rst         (rst),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .awaddr_i    (awaddr_i),
    .awid_i      (awid_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .araddr_i    (araddr_i),
    .arid_i      (arid_i),
    .arlen_i     (arlen_i),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .rdata_o     (rdata_o),
    .rid_o       (rid_o),
    .rlast_o     (rlast_o),
    .rresp_o     (rresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .bid_o       (bid_o),
    .bresp_o     (bresp_o),
    .req_valid_o (req_valid),
    .req_write_o (req_write),
    .req_addr_o  (req_addr),
    .req_len_o   (req_len),
    .req_strb_o  (req_strb),
    .req_data_o  (req_data),
    .beat_valid_i(beat_valid),
    .beat_data_i (beat_data),
    .beat_ready_o(beat_ready),
    .done_i      (done)
  );

  dram_seq i_seq (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid),
    .req_write_i (req_write),
    .req_addr_i  (req_addr),
    .req_len_i   (req_len),
    .req_strb_i  (req_strb),
    .req_data_i  (req_data),
    .beat_valid_o(beat_valid),
    .beat_data_o (beat_data),
    .beat_ready_i(beat_ready),
    .done_o      (done),
    .dram_csn_o  (dram_csn_o),
    .dram_rasn_o (dram_rasn_o),
    .dram_casn_o (dram_casn_o),
    .dram_wen_o  (dram_wen_o),
    .dram_a_o    (dram_a_o),
    .dram_d_o    (dram_d_o),
    .dram_q_i    (dram_q_i),
    .dram_valid_i(dram_valid_i)
  );

endmodule

`default_nettype wire

/* dv/dram_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dram_params.svh"

module dram_model (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    csn_i,
  input  wire logic                    rasn_i,
  input  wire logic                    casn_i,
  input  wire logic [`DRAM_STRB_W-1:0] wen_i,
  input  wire logic [`DRAM_ROW_W-1:0]  a_i,
  input  wire logic [`DRAM_DATA_W-1:0] d_i,
  output logic [`DRAM_DATA_W-1:0]      q_o,
  output logic                         valid_o
);

  localparam int WADDR_W = `DRAM_ROW_W + `DRAM_COL_W;

  logic [`DRAM_DATA_W-1:0] mem [logic [WADDR_W-1:0]];
  logic [`DRAM_ROW_W-1:0]  row_q;
  logic [WADDR_W-1:0]      rd_addr_q;
  logic [2:0]              wait_q;
  logic                    pending_q;
  integer                  seed;

  initial seed = 32'hc15e2f43;

  // Unwritten words hold a pattern built from the full word address
  function automatic logic [`DRAM_DATA_W-1:0] read_word(input logic [WADDR_W-1:0] waddr);
    if (mem.exists(waddr)) begin
      return mem[waddr];
    end
    return {waddr[10:0], waddr};
  endfunction

  always @(posedge clk or negedge rst) begin : model_ff
    logic [`DRAM_DATA_W-1:0] word;
    logic [31:0]             rnd;
    if (!rst) begin
      row_q     <= '0;
      rd_addr_q <= '0;
      wait_q    <= '0;
      pending_q <= 1'b0;
      valid_o   <= 1'b0;
      q_o       <= '0;
    end else begin
      valid_o <= 1'b0;
      // Activate latches the row, precharge drives the write enables low
      if (!csn_i && !rasn_i && (&wen_i)) begin
        row_q <= a_i;
      end
      if (!csn_i && !casn_i) begin
        if (&wen_i) begin
          if (!pending_q) begin
            rnd       = $random(seed);
            rd_addr_q <= {row_q, a_i[`DRAM_COL_W-1:0]};
            wait_q    <= 3'(rnd[1:0]) + 3'd1;
            pending_q <= 1'b1;
          end
        end else begin
          word = read_word({row_q, a_i[`DRAM_COL_W-1:0]});
          for (int k = 0; k < `DRAM_STRB_W; k++) begin
            if (!wen_i[k]) word[8*k +: 8] = d_i[8*k +: 8];
          end
          mem[{row_q, a_i[`DRAM_COL_W-1:0]}] = word;
        end
      end
      // Read access time of 1 to 4 cycles
      if (pending_q) begin
        if (wait_q == 3'd1) begin
          valid_o   <= 1'b1;
          q_o       <= read_word(rd_addr_q);
          pending_q <= 1'b0;
        end else begin
          wait_q <= wait_q - 3'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_dram_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dram_params.svh"

module tb_dram_subsys;

  localparam int TIMEOUT = 200;

  logic                        clk;
  logic                        rst;
  logic                        awvalid_i;
  logic                        awready_o;
  logic [`DRAM_AXI_ADDR_W-1:0] awaddr_i;
  logic [`DRAM_ID_W-1:0]       awid_i;
  logic                        wvalid_i;
  logic                        wready_o;
  logic [`DRAM_DATA_W-1:0]     wdata_i;
  logic [`DRAM_STRB_W-1:0]     wstrb_i;
  logic                        arvalid_i;
  logic                        arready_o;
  logic [`DRAM_AXI_ADDR_W-1:0] araddr_i;
  logic [`DRAM_ID_W-1:0]       arid_i;
  logic [`DRAM_LEN_W-1:0]      arlen_i;
  logic                        rvalid_o;
  logic                        rready_i;
  logic [`DRAM_DATA_W-1:0]     rdata_o;
  logic [`DRAM_ID_W-1:0]       rid_o;
  logic                        rlast_o;
  logic [1:0]                  rresp_o;
  logic                        bvalid_o;
  logic                        bready_i;
  logic [`DRAM_ID_W-1:0]       bid_o;
  logic [1:0]                  bresp_o;
  logic                        dram_csn;
  logic                        dram_rasn;
  logic                        dram_casn;
  logic [`DRAM_STRB_W-1:0]     dram_wen;
  logic [`DRAM_ROW_W-1:0]      dram_a;
  logic [`DRAM_DATA_W-1:0]     dram_d;
  logic [`DRAM_DATA_W-1:0]     dram_q;
  logic                        dram_valid;
  integer                      seed;
  int                          n_tx;

  // Expected memory contents, keyed by word address
  logic [`DRAM_DATA_W-1:0] shadow [logic [20:0]];

  always #10 clk = ~clk;

  dram_subsys i_dut (
    .clk(clk), .rst(rst),
    .awvalid_i(awvalid_i), .awready_o(awready_o), .awaddr_i(awaddr_i), .awid_i(awid_i),
    .wvalid_i(wvalid_i), .wready_o(wready_o), .wdata_i(wdata_i), .wstrb_i(wstrb_i),
    .arvalid_i(arvalid_i), .arready_o(arready_o), .araddr_i(araddr_i), .arid_i(arid_i),
    .arlen_i(arlen_i),
    .rvalid_o(rvalid_o), .rready_i(rready_i), .rdata_o(rdata_o), .rid_o(rid_o),
    .rlast_o(rlast_o), .rresp_o(rresp_o),
    .bvalid_o(bvalid_o), .bready_i(bready_i), .bid_o(bid_o), .bresp_o(bresp_o),
    .dram_csn_o(dram_csn), .dram_rasn_o(dram_rasn), .dram_casn_o(dram_casn),
    .dram_wen_o(dram_wen), .dram_a_o(dram_a), .dram_d_o(dram_d),
    .dram_q_i(dram_q), .dram_valid_i(dram_valid)
  );

  dram_model i_dram (
    .clk(clk), .rst(rst), .csn_i(dram_csn), .rasn_i(dram_rasn), .casn_i(dram_casn),
    .wen_i(dram_wen), .a_i(dram_a), .d_i(dram_d), .q_o(dram_q), .valid_o(dram_valid)
  );

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic drive_edge();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [`DRAM_DATA_W-1:0] expected_word(input logic [20:0] waddr);
    if (shadow.exists(waddr)) begin
      return shadow[waddr];
    end
    return {waddr[10:0], waddr};
  endfunction

  task automatic compare_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %b exp %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_rbeat(input logic [`DRAM_DATA_W-1:0] exp_data,
                             input logic [`DRAM_ID_W-1:0] exp_id, input logic exp_last);
    if (rdata_o !== exp_data) begin
      $display("ERROR %0t rdata_o got %h exp %h", $time, rdata_o, exp_data);
      stop_run();
    end
    if (rid_o !== exp_id) begin
      $display("ERROR %0t rid_o got %h exp %h", $time, rid_o, exp_id);
      stop_run();
    end
    if (rlast_o !== exp_last) begin
      $display("ERROR %0t rlast_o got %b exp %b", $time, rlast_o, exp_last);
      stop_run();
    end
    if (rresp_o !== 2'b00) begin
      $display("ERROR %0t rresp_o got %b exp %b", $time, rresp_o, 2'b00);
      stop_run();
    end
  endtask

  task automatic check_bresp(input logic [`DRAM_ID_W-1:0] exp_id, input logic [1:0] exp_resp);
    if (bvalid_o !== 1'b1) begin
      $display("ERROR %0t bvalid_o got %b exp %b", $time, bvalid_o, 1'b1);
      stop_run();
    end
    if (bid_o !== exp_id) begin
      $display("ERROR %0t bid_o got %h exp %h", $time, bid_o, exp_id);
      stop_run();
    end
    if (bresp_o !== exp_resp) begin
      $display("ERROR %0t bresp_o got %b exp %b", $time, bresp_o, exp_resp);
      stop_run();
    end
  endtask

  task automatic write_word(input logic [`DRAM_ID_W-1:0] id,
                            input logic [`DRAM_AXI_ADDR_W-1:0] addr,
                            input logic [`DRAM_STRB_W-1:0] strb,
                            input logic [`DRAM_DATA_W-1:0] data, input int hold);
    int                      n;
    logic [20:0]             waddr;
    logic [`DRAM_DATA_W-1:0] word;
    waddr     = addr[22:2];
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    awid_i    = id;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    bready_i  = (hold == 0);
    n = 0;
    @(negedge clk);
    while (!awready_o) begin
      n++;
      if (n > TIMEOUT) begin
        $display("Timed out waiting for the write address to be accepted");
        stop_run();
      end
      @(negedge clk);
    end
    compare_level("wready_o", wready_o, 1'b1);
    drive_edge();
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    // Only strobed bytes change
    word = expected_word(waddr);
    for (int k = 0; k < `DRAM_STRB_W; k++) begin
      if (strb[k]) word[8*k +: 8] = data[8*k +: 8];
    end
    shadow[waddr] = word;
    n = 0;
    @(negedge clk);
    while (!bvalid_o) begin
      n++;
      if (n > TIMEOUT) begin
        $display("Timed out waiting for the write response");
        stop_run();
      end
      @(negedge clk);
    end
    if (hold > 0) begin
      // A pending read must not be accepted before the B handshake
      drive_edge();
      arvalid_i = 1'b1;
      araddr_i  = addr;
      arid_i    = id;
      arlen_i   = '0;
      repeat (hold) begin
        @(negedge clk);
        check_bresp(id, 2'b00);
        compare_level("arready_o", arready_o, 1'b0);
        drive_edge();
      end
      bready_i  = 1'b1;
      @(negedge clk);
    end
    check_bresp(id, 2'b00);
    drive_edge();
    if (hold > 0) begin
      // The held read is taken once the write response is gone
      read_burst(id, addr, '0, 0);
    end
  endtask

  task automatic read_burst(input logic [`DRAM_ID_W-1:0] id,
                            input logic [`DRAM_AXI_ADDR_W-1:0] addr,
                            input logic [`DRAM_LEN_W-1:0] len, input int stall);
    int          n;
    int          b;
    logic        accepted;
    logic [20:0] waddr;
    logic [31:0] rnd;
    arvalid_i = 1'b1;
    araddr_i  = addr;
    arid_i    = id;
    arlen_i   = len;
    n = 0;
    @(negedge clk);
    while (!arready_o) begin
      n++;
      if (n > TIMEOUT) begin
        $display("Timed out waiting for the read address to be accepted");
        stop_run();
      end
      @(negedge clk);
    end
    drive_edge();
    arvalid_i = 1'b0;
    for (b = 0; b <= int'(len); b++) begin
      waddr    = addr[22:2] + 21'(b);
      accepted = 1'b0;
      n = 0;
      while (!accepted) begin
        if (stall != 0) begin
          rnd      = $random(seed);
          rready_i = rnd[0];
        end
        @(negedge clk);
        // Stalled beats are compared every cycle, so any change shows up
        if (rvalid_o) begin
          check_rbeat(expected_word(waddr), id, b == int'(len));
          accepted = rready_i;
        end
        n++;
        if (n > TIMEOUT) begin
          $display("Timed out waiting for read beat %0d", b);
          stop_run();
        end
        drive_edge();
      end
    end
    rready_i = 1'b1;
  endtask

  initial begin
    int                          fd;
    int                          cnt;
    string                       line;
    logic [7:0]                  op;
    logic [`DRAM_ID_W-1:0]       id;
    logic [`DRAM_AXI_ADDR_W-1:0] addr;
    logic [`DRAM_LEN_W-1:0]      len;
    logic [`DRAM_STRB_W-1:0]     strb;
    logic [`DRAM_DATA_W-1:0]     data;
    int                          hold;
    clk       = 1'b0;
    rst       = 1'b0;
    seed      = 32'hc15e2f43;
    awvalid_i = 1'b0;
    awaddr_i  = '0;
    awid_i    = '0;
    wvalid_i  = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    arvalid_i = 1'b0;
    araddr_i  = '0;
    arid_i    = '0;
    arlen_i   = '0;
    rready_i  = 1'b1;
    bready_i  = 1'b1;
    n_tx      = 0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b1;
    // Idle levels straight after reset
    @(negedge clk);
    compare_level("awready_o", awready_o, 1'b0);
    compare_level("wready_o", wready_o, 1'b0);
    compare_level("arready_o", arready_o, 1'b0);
    compare_level("rvalid_o", rvalid_o, 1'b0);
    compare_level("bvalid_o", bvalid_o, 1'b0);
    compare_level("dram_csn_o", dram_csn, 1'b1);
    compare_level("dram_rasn_o", dram_rasn, 1'b1);
    compare_level("dram_casn_o", dram_casn, 1'b1);
    for (int k = 0; k < `DRAM_STRB_W; k++) begin
      compare_level($sformatf("dram_wen_o[%0d]", k), dram_wen[k], 1'b1);
    end
    fd = $fopen("dv/dram_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open dv/dram_testdata.txt");
      stop_run();
    end
    drive_edge();
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%s %h %h %h %h %h %d", op, id, addr, len, strb, data, hold);
      if (cnt != 7) begin
        $display("Malformed line in the test data file");
        stop_run();
      end
      if (op == "W") begin
        write_word(id, addr, strb, data, hold);
      end else if (op == "R") begin
        read_burst(id, addr, len, hold);
      end else begin
        $display("Unknown operation in the test data file");
        stop_run();
      end
      n_tx++;
    end
    $fclose(fd);
    if (n_tx == 0) begin
      $display("The test data file holds no transactions");
      stop_run();
    end else begin
      $display("%0d transactions checked", n_tx);
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/dram_testdata.txt */
# columns are op id addr len strb data hold, all hex except hold which is decimal
# for W hold is the cycles bready_i stays low, for R hold 1 enables random rready_i stalls
W 3 000100 0 f 11223344 0
R 5 000100 0 0 00000000 0
W 1 012340 0 f cafef00d 0
W 2 012340 0 3 0000beef 0
W 4 012340 0 8 a5000000 0
R 6 012340 0 0 00000000 0
W 7 7ff010 0 f 01020304 0
R 8 7ff000 f 0 00000000 0
W 9 234ff8 0 f 0badf00d 0
R a 234fc0 f 0 00000000 1
W b 000200 0 f 13579bdf 6
R c 000200 0 0 00000000 0
W d 400804 0 6 00ffff00 0
R e 400800 3 0 00000000 1
R 0 012340 1 0 00000000 1
W f 100000 0 f deadbeef 3
R 1 100000 7 0 00000000 1
W 2 100008 0 1 000000aa 0
R 3 100000 3 0 00000000 1

/* tb.f */
+incdir+rtl
rtl/dram_pkg.sv
rtl/dram_axi_slave.sv
rtl/dram_seq.sv
rtl/dram_subsys.sv
dv/dram_model.sv
dv/tb_dram_subsys.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module tb_dram_subsys -o tb_dram_subsys &&
  ./obj_dir/tb_dram_subsys ||
  { echo "simulation did not pass"; exit 1; }
